// File: ddram_consts.svh
`ifndef DDRAM_CONSTS_SVH
`define DDRAM_CONSTS_SVH

// number of client ports served by the bridge
`define DDRAM_CHANNELS 2

// write queue address width, eight entries per client
`define DDRAM_FIFO_DEPTH_LOG2 3

// 64-bit words per cached line, also the read burst length
`define DDRAM_LINE_WORDS 4

// upper DDR word address bits, memory window at 0x30000000
`define DDRAM_BASE 7'b0011000

`endif

// File: ddr_bus_pkg.sv
package ddr_bus_pkg;

	// DDR word address, one unit per 64-bit word
	typedef logic [28:0] ddr_addr_t;

	typedef logic [63:0] ddr_data_t;
	typedef logic [7:0]  ddr_be_t;
	typedef logic [7:0]  ddr_burst_t;

	// word position inside a cached line
	typedef logic [1:0]  word_idx_t;

	// bus sequencer states
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_WRITE_DONE,
		ARB_FILL
	} arb_state_t;

endpackage

// File: mem_port_pkg.sv
`include "ddram_consts.svh"

package mem_port_pkg;

	// client halfword address, bit 0 here is client address bit 1
	typedef logic [23:0] mem_addr_t;

	typedef logic [31:0] mem_data_t;

	// one bit per client byte lane
	typedef logic [3:0]  wr_mask_t;

	// client address bits 24 down to 5
	typedef logic [19:0] line_tag_t;

	typedef logic [$clog2(`DDRAM_CHANNELS)-1:0] chan_t;

	// queued write, 60 bits
	typedef struct packed {
		mem_addr_t addr;
		wr_mask_t  mask;
		mem_data_t data;
	} write_entry_t;

endpackage

// File: ddr_write_fifo.sv
`timescale 1ns/1ps
`include "ddram_consts.svh"

module ddr_write_fifo (
	input  logic                       clk,
	input  logic                       rst_pulse,
	input  mem_port_pkg::write_entry_t din,
	input  logic                       push,
	input  logic                       pop,
	output mem_port_pkg::write_entry_t dout,
	output logic                       empty,
	output logic                       full
);
	import mem_port_pkg::*;

	localparam int DEPTH = 2 ** `DDRAM_FIFO_DEPTH_LOG2;

	write_entry_t entries [DEPTH];
	logic [`DDRAM_FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [`DDRAM_FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic [`DDRAM_FIFO_DEPTH_LOG2:0]   count;
	logic do_push;
	logic do_pop;

	// overflow and underflow requests are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			entries[wr_ptr] <= din;
	end

	// head of queue, no read latency
	assign dout  = entries[rd_ptr];
	assign empty = (count == '0);
	assign full  = count[`DDRAM_FIFO_DEPTH_LOG2];

	// the client port must hold off writes while busy is shown
	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (rst_pulse) push |-> !full
	) else $error("write queue overflow");

endmodule

// File: ddr_line_cache.sv
`timescale 1ns/1ps
`include "ddram_consts.svh"

module ddr_line_cache (
	input  logic                    clk,
	input  logic                    rst_pulse,
	input  logic                    rd_start,
	input  mem_port_pkg::mem_addr_t addr,
	input  logic                    word16,
	input  logic                    fill_we,
	input  ddr_bus_pkg::word_idx_t  fill_idx,
	input  ddr_bus_pkg::ddr_data_t  fill_data,
	input  ddr_bus_pkg::ddr_be_t    fill_be,
	input  logic                    fill_done,
	output mem_port_pkg::line_tag_t tag,
	output logic                    rd_pending,
	output mem_port_pkg::mem_data_t dout
);
	import ddr_bus_pkg::*;
	import mem_port_pkg::*;

	ddr_data_t line_mem [`DDRAM_LINE_WORDS];
	line_tag_t req_tag;
	word_idx_t rd_idx;
	logic [1:0] rd_lane;
	logic rd_word16;
	ddr_data_t rd_word;

	assign req_tag = addr[23:4];

	// tag and miss flag
	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			tag        <= '1;
			rd_pending <= 1'b0;
		end else if (rd_start) begin
			if (req_tag != tag)
				rd_pending <= 1'b1;
			tag <= req_tag;
		end else if (fill_done) begin
			rd_pending <= 1'b0;
		end
	end

	// read position, held until the next rd edge
	always_ff @(posedge clk) begin
		if (rd_start) begin
			rd_idx    <= addr[3:2];
			rd_lane   <= addr[1:0];
			rd_word16 <= word16;
		end
	end

	// byte-enabled line storage, written by fills and write updates
	always_ff @(posedge clk) begin
		if (fill_we) begin
			for (int b = 0; b < 8; b++) begin
				if (fill_be[b])
					line_mem[fill_idx][8*b +: 8] <= fill_data[8*b +: 8];
			end
		end
	end

	assign rd_word = line_mem[rd_idx];

	// lane 0 sits at the most significant end of the word
	always_comb begin
		if (rd_word16) begin
			case (rd_lane)
				2'b00:   dout = {16'h0000, rd_word[63:48]};
				2'b01:   dout = {16'h0000, rd_word[47:32]};
				2'b10:   dout = {16'h0000, rd_word[31:16]};
				default: dout = {16'h0000, rd_word[15:0]};
			endcase
		end else begin
			dout = rd_lane[1] ? rd_word[31:0] : rd_word[63:32];
		end
	end

	// arbiter only completes a fill that this client asked for
	a_fill_done_pending: assert property (
		@(posedge clk) disable iff (rst_pulse) fill_done |-> rd_pending
	) else $error("line fill completed without a pending miss");

endmodule

// File: ddr_client_port.sv
`timescale 1ns/1ps

module ddr_client_port (
	input  logic                    clk,
	input  logic                    rst_pulse,
	input  mem_port_pkg::mem_addr_t addr,
	input  mem_port_pkg::mem_data_t din,
	input  logic                    rd,
	input  mem_port_pkg::wr_mask_t  wr,
	input  logic                    word16,
	output mem_port_pkg::mem_data_t dout,
	output logic                    busy,
	output logic                    wr_pending,
	output mem_port_pkg::mem_addr_t wr_addr,
	output ddr_bus_pkg::ddr_data_t  wr_data,
	output ddr_bus_pkg::ddr_be_t    wr_be,
	input  logic                    pop,
	output logic                    rd_pending,
	output mem_port_pkg::line_tag_t tag,
	input  logic                    fill_we,
	input  ddr_bus_pkg::word_idx_t  fill_idx,
	input  ddr_bus_pkg::ddr_data_t  fill_data,
	input  ddr_bus_pkg::ddr_be_t    fill_be,
	input  logic                    fill_done
);
	import mem_port_pkg::*;

	write_entry_t push_entry;
	write_entry_t head;
	logic old_rd;
	logic old_wr;
	logic rd_edge;
	logic wr_edge;
	logic fifo_empty;
	logic fifo_full;

	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			old_rd <= 1'b0;
			old_wr <= 1'b0;
		end else begin
			old_rd <= rd;
			old_wr <= |wr;
		end
	end

	assign rd_edge = rd && !old_rd;
	assign wr_edge = |wr && !old_wr;

	assign push_entry = {addr, wr, din};

	ddr_write_fifo u_fifo (
		.clk       (clk),
		.rst_pulse (rst_pulse),
		.din       (push_entry),
		.push      (wr_edge),
		.pop       (pop),
		.dout      (head),
		.empty     (fifo_empty),
		.full      (fifo_full)
	);

	assign wr_pending = !fifo_empty;
	assign wr_addr    = head.addr;

	// replicate data across the 64-bit word, enable only the addressed lanes
	always_comb begin
		if (word16) begin
			wr_data = {4{head.data[15:0]}};
			wr_be   = {head.mask[1:0], 6'b000000} >> {head.addr[1:0], 1'b0};
		end else begin
			wr_data = {2{head.data}};
			wr_be   = {head.mask, 4'b0000} >> {head.addr[1], 2'b00};
		end
	end

	ddr_line_cache u_cache (
		.clk        (clk),
		.rst_pulse  (rst_pulse),
		.rd_start   (rd_edge),
		.addr       (addr),
		.word16     (word16),
		.fill_we    (fill_we),
		.fill_idx   (fill_idx),
		.fill_data  (fill_data),
		.fill_be    (fill_be),
		.fill_done  (fill_done),
		.tag        (tag),
		.rd_pending (rd_pending),
		.dout       (dout)
	);

	assign busy = fifo_full | rd_pending;

endmodule

// File: ddr_arbiter.sv
`timescale 1ns/1ps
`include "ddram_consts.svh"

module ddr_arbiter (
	input  logic                    clk,
	input  logic                    rst_pulse,
	input  logic                    wr_pending [`DDRAM_CHANNELS],
	input  logic                    rd_pending [`DDRAM_CHANNELS],
	input  mem_port_pkg::mem_addr_t wr_addr [`DDRAM_CHANNELS],
	input  ddr_bus_pkg::ddr_data_t  wr_data [`DDRAM_CHANNELS],
	input  ddr_bus_pkg::ddr_be_t    wr_be [`DDRAM_CHANNELS],
	input  mem_port_pkg::line_tag_t tag [`DDRAM_CHANNELS],
	output logic                    pop [`DDRAM_CHANNELS],
	output logic                    fill_we [`DDRAM_CHANNELS],
	output logic                    fill_done [`DDRAM_CHANNELS],
	output ddr_bus_pkg::word_idx_t  fill_idx,
	output ddr_bus_pkg::ddr_data_t  fill_data,
	output ddr_bus_pkg::ddr_be_t    fill_be,
	input  logic                    ddram_busy,
	output ddr_bus_pkg::ddr_addr_t  ddram_addr,
	output ddr_bus_pkg::ddr_burst_t ddram_burstcnt,
	output logic                    ddram_rd,
	output logic                    ddram_we,
	output ddr_bus_pkg::ddr_data_t  ddram_din,
	output ddr_bus_pkg::ddr_be_t    ddram_be,
	input  ddr_bus_pkg::ddr_data_t  ddram_dout,
	input  logic                    ddram_dout_ready
);
	import ddr_bus_pkg::*;
	import mem_port_pkg::*;

	arb_state_t state;
	chan_t chan_q;
	chan_t sel_chan;
	word_idx_t idx_q;
	logic sel_found;
	logic sel_write;
	logic update_q;
	logic last_beat;

	// fixed priority, lower client first and its write before its read
	always_comb begin
		sel_found = 1'b0;
		sel_write = 1'b0;
		sel_chan  = '0;
		for (int i = 0; i < `DDRAM_CHANNELS; i++) begin
			if (!sel_found && (wr_pending[i] || rd_pending[i])) begin
				sel_found = 1'b1;
				sel_write = wr_pending[i];
				sel_chan  = chan_t'(i);
			end
		end
	end

	assign last_beat = (idx_q == word_idx_t'(`DDRAM_LINE_WORDS - 1));

	// everything freezes while the memory stalls
	always_ff @(posedge clk) begin
		if (rst_pulse) begin
			state    <= ARB_IDLE;
			ddram_rd <= 1'b0;
			ddram_we <= 1'b0;
		end else if (!ddram_busy) begin
			ddram_rd <= 1'b0;
			ddram_we <= 1'b0;
			case (state)
				ARB_IDLE: begin
					if (sel_found) begin
						chan_q <= sel_chan;
						if (sel_write) begin
							ddram_addr     <= {`DDRAM_BASE, wr_addr[sel_chan][23:2]};
							ddram_din      <= wr_data[sel_chan];
							ddram_be       <= wr_be[sel_chan];
							ddram_burstcnt <= 8'd1;
							ddram_we       <= 1'b1;
							idx_q          <= wr_addr[sel_chan][3:2];
							// keep a cached copy of this line coherent
							update_q       <= (wr_addr[sel_chan][23:4] == tag[sel_chan]);
							state          <= ARB_WRITE_DONE;
						end else begin
							ddram_addr     <= {`DDRAM_BASE, tag[sel_chan], 2'b00};
							ddram_be       <= '1;
							ddram_burstcnt <= ddr_burst_t'(`DDRAM_LINE_WORDS);
							ddram_rd       <= 1'b1;
							idx_q          <= '0;
							state          <= ARB_FILL;
						end
					end
				end
				ARB_WRITE_DONE: begin
					state <= ARB_IDLE;
				end
				ARB_FILL: begin
					if (ddram_dout_ready) begin
						idx_q <= idx_q + 1'b1;
						if (last_beat)
							state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// shared cache write bus, fill beats or the write just issued
	assign fill_idx  = idx_q;
	assign fill_data = (state == ARB_FILL) ? ddram_dout : ddram_din;
	assign fill_be   = (state == ARB_FILL) ? '1 : ddram_be;

	always_comb begin
		for (int i = 0; i < `DDRAM_CHANNELS; i++) begin
			pop[i] = !ddram_busy && state == ARB_IDLE && sel_found && sel_write
				&& sel_chan == chan_t'(i);
			fill_we[i] = !ddram_busy && chan_q == chan_t'(i)
				&& ((state == ARB_WRITE_DONE && update_q)
				|| (state == ARB_FILL && ddram_dout_ready));
			fill_done[i] = !ddram_busy && chan_q == chan_t'(i) && state == ARB_FILL
				&& ddram_dout_ready && last_beat;
		end
	end

	a_rd_we_exclusive: assert property (
		@(posedge clk) disable iff (rst_pulse) !(ddram_rd && ddram_we)
	) else $error("read and write issued together");

	a_ready_in_fill: assert property (
		@(posedge clk) disable iff (rst_pulse) ddram_dout_ready |-> state == ARB_FILL
	) else $error("data ready beat outside a line fill");

endmodule

// File: ddram.sv
`timescale 1ns/1ps
`include "ddram_consts.svh"

module ddram (
	input  logic                    clk,
	input  logic                    rst_pulse,
	input  mem_port_pkg::mem_addr_t mem_addr [`DDRAM_CHANNELS],
	input  mem_port_pkg::mem_data_t mem_din [`DDRAM_CHANNELS],
	input  logic                    mem_rd [`DDRAM_CHANNELS],
	input  mem_port_pkg::wr_mask_t  mem_wr [`DDRAM_CHANNELS],
	input  logic                    mem_16b [`DDRAM_CHANNELS],
	output mem_port_pkg::mem_data_t mem_dout [`DDRAM_CHANNELS],
	output logic                    mem_busy [`DDRAM_CHANNELS],
	input  logic                    ddram_busy,
	output ddr_bus_pkg::ddr_addr_t  ddram_addr,
	output ddr_bus_pkg::ddr_burst_t ddram_burstcnt,
	output logic                    ddram_rd,
	output logic                    ddram_we,
	output ddr_bus_pkg::ddr_data_t  ddram_din,
	output ddr_bus_pkg::ddr_be_t    ddram_be,
	input  ddr_bus_pkg::ddr_data_t  ddram_dout,
	input  logic                    ddram_dout_ready
);
	import ddr_bus_pkg::*;
	import mem_port_pkg::*;

	logic      wr_pending [`DDRAM_CHANNELS];
	logic      rd_pending [`DDRAM_CHANNELS];
	mem_addr_t wr_addr [`DDRAM_CHANNELS];
	ddr_data_t wr_data [`DDRAM_CHANNELS];
	ddr_be_t   wr_be [`DDRAM_CHANNELS];
	line_tag_t tag [`DDRAM_CHANNELS];
	logic      pop [`DDRAM_CHANNELS];
	logic      fill_we [`DDRAM_CHANNELS];
	logic      fill_done [`DDRAM_CHANNELS];
	word_idx_t fill_idx;
	ddr_data_t fill_data;
	ddr_be_t   fill_be;

	for (genvar g = 0; g < `DDRAM_CHANNELS; g++) begin : g_client
		ddr_client_port u_port (
			.clk        (clk),
			.rst_pulse  (rst_pulse),
			.addr       (mem_addr[g]),
			.din        (mem_din[g]),
			.rd         (mem_rd[g]),
			.wr         (mem_wr[g]),
			.word16     (mem_16b[g]),
			.dout       (mem_dout[g]),
			.busy       (mem_busy[g]),
			.wr_pending (wr_pending[g]),
			.wr_addr    (wr_addr[g]),
			.wr_data    (wr_data[g]),
			.wr_be      (wr_be[g]),
			.pop        (pop[g]),
			.rd_pending (rd_pending[g]),
			.tag        (tag[g]),
			.fill_we    (fill_we[g]),
			.fill_idx   (fill_idx),
			.fill_data  (fill_data),
			.fill_be    (fill_be),
			.fill_done  (fill_done[g])
		);
	end

	ddr_arbiter u_arbiter (
		.clk              (clk),
		.rst_pulse        (rst_pulse),
		.wr_pending       (wr_pending),
		.rd_pending       (rd_pending),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.wr_be            (wr_be),
		.tag              (tag),
		.pop              (pop),
		.fill_we          (fill_we),
		.fill_done        (fill_done),
		.fill_idx         (fill_idx),
		.fill_data        (fill_data),
		.fill_be          (fill_be),
		.ddram_busy       (ddram_busy),
		.ddram_addr       (ddram_addr),
		.ddram_burstcnt   (ddram_burstcnt),
		.ddram_rd         (ddram_rd),
		.ddram_we         (ddram_we),
		.ddram_din        (ddram_din),
		.ddram_be         (ddram_be),
		.ddram_dout       (ddram_dout),
		.ddram_dout_ready (ddram_dout_ready)
	);

endmodule

// File: tb_ddram_checker.sv
`timescale 1ns/1ps
`include "ddram_consts.svh"

module tb_ddram_checker (
	input  logic                    clk,
	input  logic                    rst_pulse,
	input  logic                    mem_rd [`DDRAM_CHANNELS],
	input  logic                    mem_busy [`DDRAM_CHANNELS],
	input  mem_port_pkg::mem_data_t mem_dout [`DDRAM_CHANNELS],
	input  logic                    ddram_busy,
	input  logic                    ddram_rd,
	input  logic                    ddram_we,
	input  ddr_bus_pkg::ddr_addr_t  ddram_addr,
	input  ddr_bus_pkg::ddr_burst_t ddram_burstcnt
);
	import ddr_bus_pkg::*;
	import mem_port_pkg::*;

	int error_count = 0;
	int check_count = 0;
	int reads_done = 0;

	// per client read under way
	string     rd_name [`DDRAM_CHANNELS];
	mem_data_t rd_expect [`DDRAM_CHANNELS];
	logic      rd_miss [`DDRAM_CHANNELS];
	logic      rd_armed [`DDRAM_CHANNELS];
	logic      rd_first [`DDRAM_CHANNELS];
	logic      rd_seen [`DDRAM_CHANNELS];

	// DDR writes in the order they must appear on the bus
	string     wr_names [$];
	ddr_addr_t wr_addrs [$];
	string     last_name = "reset";

	task automatic expect_read(input string name, input int client, input mem_data_t value,
		input logic miss);
		rd_name[client]   = name;
		rd_expect[client] = value;
		rd_miss[client]   = miss;
		last_name         = name;
	endtask

	task automatic expect_write(input string name, input ddr_addr_t addr);
		wr_names.push_back(name);
		wr_addrs.push_back(addr);
		last_name = name;
	endtask

	function automatic int writes_outstanding();
		return wr_addrs.size();
	endfunction

	// outputs are settled half a cycle after the rising edge
	always @(negedge clk) begin : watch
		ddr_addr_t exp_addr;
		string     exp_name;
		if (rst_pulse) begin
			for (int c = 0; c < `DDRAM_CHANNELS; c++) begin
				rd_armed[c] = 1'b0;
				rd_first[c] = 1'b0;
				rd_seen[c]  = 1'b0;
			end
		end else begin
			for (int c = 0; c < `DDRAM_CHANNELS; c++) begin
				// one clock after the rd edge busy tells a miss from a hit
				if (rd_armed[c] && rd_first[c]) begin
					check_count++;
					if (mem_busy[c] !== rd_miss[c]) begin
						error_count++;
						$display("error %s: expected busy %b, actual %b",
							rd_name[c], rd_miss[c], mem_busy[c]);
					end
					rd_first[c] = 1'b0;
				end
				// read is over once busy is low after the rd edge
				if (rd_armed[c] && !mem_busy[c]) begin
					check_count++;
					reads_done++;
					if (mem_dout[c] !== rd_expect[c]) begin
						error_count++;
						$display("error %s: expected %h, actual %h",
							rd_name[c], rd_expect[c], mem_dout[c]);
					end
					rd_armed[c] = 1'b0;
				end
				if (mem_rd[c] && !rd_seen[c]) begin
					rd_armed[c] = 1'b1;
					rd_first[c] = 1'b1;
				end
				rd_seen[c] = mem_rd[c];
			end

			// accepted bus cycles
			if (!ddram_busy && ddram_we) begin
				if (wr_addrs.size() == 0) begin
					error_count++;
					$display("DDR write to %h appeared although no write was queued", ddram_addr);
				end else begin
					exp_addr = wr_addrs.pop_front();
					exp_name = wr_names.pop_front();
					check_count++;
					if (ddram_addr !== exp_addr) begin
						error_count++;
						$display("error %s: expected address %h, actual %h",
							exp_name, exp_addr, ddram_addr);
					end
					if (ddram_burstcnt !== 8'd1) begin
						error_count++;
						$display("error %s: expected burst %0d, actual %0d",
							exp_name, 1, ddram_burstcnt);
					end
				end
			end
			if (!ddram_busy && ddram_rd) begin
				check_count++;
				if (ddram_burstcnt !== 8'(`DDRAM_LINE_WORDS)) begin
					error_count++;
					$display("error %s: expected burst %0d, actual %0d",
						last_name, `DDRAM_LINE_WORDS, ddram_burstcnt);
				end
			end
		end
	end

endmodule

// File: tb_ddram.sv
`timescale 1ns/1ps
`include "ddram_consts.svh"

module tb_ddram;
	import ddr_bus_pkg::*;
	import mem_port_pkg::*;

	localparam int N_ROWS      = 20;
	localparam int CYCLE_LIMIT = 40 * N_ROWS;
	localparam int OP_WR       = 0;
	// write that goes out on the same clock as the next row
	localparam int OP_WR_POST  = 1;
	localparam int OP_RD       = 2;
	// four halfwords per 64-bit word
	localparam int LINE_SHIFT  = 2 + $clog2(`DDRAM_LINE_WORDS);

	logic      clk;
	logic      rst_pulse = 1'b1;
	mem_addr_t mem_addr [`DDRAM_CHANNELS];
	mem_data_t mem_din [`DDRAM_CHANNELS];
	logic      mem_rd [`DDRAM_CHANNELS];
	wr_mask_t  mem_wr [`DDRAM_CHANNELS];
	logic      mem_16b [`DDRAM_CHANNELS];
	mem_data_t mem_dout [`DDRAM_CHANNELS];
	logic      mem_busy [`DDRAM_CHANNELS];

	logic       ddram_busy = 1'b0;
	ddr_data_t  ddram_dout = '0;
	logic       ddram_dout_ready = 1'b0;
	ddr_addr_t  ddram_addr;
	ddr_burst_t ddram_burstcnt;
	logic       ddram_rd;
	logic       ddram_we;
	ddr_data_t  ddram_din;
	ddr_be_t    ddram_be;

	// stimulus table columns
	string     row_name [N_ROWS];
	int        row_client [N_ROWS];
	int        row_op [N_ROWS];
	logic      row_w16 [N_ROWS];
	mem_addr_t row_addr [N_ROWS];
	mem_data_t row_data [N_ROWS];
	wr_mask_t  row_mask [N_ROWS];
	mem_data_t row_expect [N_ROWS];

	// line each client read last, all ones after reset
	line_tag_t open_line [`DDRAM_CHANNELS];

	// memory model state
	ddr_data_t   ddr_mem [ddr_addr_t];
	ddr_addr_t   beat_addr;
	int          beats_left = 0;
	logic [31:0] rnd = 32'hd3f9_db24;

	int cycle_count = 0;
	int tb_errors = 0;

	ddram UUT (
		.clk              (clk),
		.rst_pulse        (rst_pulse),
		.mem_addr         (mem_addr),
		.mem_din          (mem_din),
		.mem_rd           (mem_rd),
		.mem_wr           (mem_wr),
		.mem_16b          (mem_16b),
		.mem_dout         (mem_dout),
		.mem_busy         (mem_busy),
		.ddram_busy       (ddram_busy),
		.ddram_addr       (ddram_addr),
		.ddram_burstcnt   (ddram_burstcnt),
		.ddram_rd         (ddram_rd),
		.ddram_we         (ddram_we),
		.ddram_din        (ddram_din),
		.ddram_be         (ddram_be),
		.ddram_dout       (ddram_dout),
		.ddram_dout_ready (ddram_dout_ready)
	);

	tb_ddram_checker checks (
		.clk            (clk),
		.rst_pulse      (rst_pulse),
		.mem_rd         (mem_rd),
		.mem_busy       (mem_busy),
		.mem_dout       (mem_dout),
		.ddram_busy     (ddram_busy),
		.ddram_rd       (ddram_rd),
		.ddram_we       (ddram_we),
		.ddram_addr     (ddram_addr),
		.ddram_burstcnt (ddram_burstcnt)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// contents of a word nobody has written yet
	function automatic ddr_data_t pattern_word(input ddr_addr_t a);
		return {3'b000, a, 3'b111, a};
	endfunction

	function automatic ddr_data_t load_word(input ddr_addr_t a);
		return ddr_mem.exists(a) ? ddr_mem[a] : pattern_word(a);
	endfunction

	task automatic store_word(input ddr_addr_t a, input ddr_data_t d, input ddr_be_t be);
		ddr_data_t w;
		w = load_word(a);
		for (int b = 0; b < 8; b++) begin
			if (be[b])
				w[8*b +: 8] = d[8*b +: 8];
		end
		ddr_mem[a] = w;
	endtask

	// DDR memory, random stalls and four beats per read burst
	always @(posedge clk) begin : ddr_model
		logic [31:0] r;
		rnd = xorshift32(rnd);
		r = rnd;
		if (rst_pulse) begin
			ddram_busy       <= 1'b0;
			ddram_dout_ready <= 1'b0;
			beats_left = 0;
		end else begin
			if (!ddram_busy && ddram_we)
				store_word(ddram_addr, ddram_din, ddram_be);
			if (!ddram_busy && ddram_rd) begin
				beat_addr  = ddram_addr;
				beats_left = `DDRAM_LINE_WORDS;
			end
			if (!ddram_busy && ddram_dout_ready) begin
				beat_addr  = beat_addr + 1'b1;
				beats_left = beats_left - 1;
			end
			if (beats_left != 0 && r[1:0] != 2'b00) begin
				ddram_busy       <= 1'b0;
				ddram_dout_ready <= 1'b1;
				ddram_dout       <= load_word(beat_addr);
			end else begin
				ddram_dout_ready <= 1'b0;
				ddram_busy       <= (r[4:3] == 2'b00);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	task automatic set_row(input int idx, input string name, input int client, input int op,
		input logic w16, input mem_addr_t addr, input mem_data_t data, input wr_mask_t mask,
		input mem_data_t expect_val);
		row_name[idx]   = name;
		row_client[idx] = client;
		row_op[idx]     = op;
		row_w16[idx]    = w16;
		row_addr[idx]   = addr;
		row_data[idx]   = data;
		row_mask[idx]   = mask;
		row_expect[idx] = expect_val;
	endtask

	// unwritten words read back as {3'b000, a} upper and {3'b111, a} lower
	task automatic load_table();
		set_row(0, "wr32_c0", 0, OP_WR, 1'b0, 24'h000100, 32'h1234_5678, 4'hf, 32'h0);
		set_row(1, "rd32_c0", 0, OP_RD, 1'b0, 24'h000100, 32'h0, 4'h0, 32'h1234_5678);
		set_row(2, "wr16_l0", 0, OP_WR, 1'b1, 24'h000204, 32'h0000_aaa1, 4'h3, 32'h0);
		set_row(3, "wr16_l1", 0, OP_WR, 1'b1, 24'h000205, 32'h0000_bbb2, 4'h3, 32'h0);
		set_row(4, "wr16_l2", 0, OP_WR, 1'b1, 24'h000206, 32'h0000_ccc3, 4'h3, 32'h0);
		set_row(5, "wr16_l3", 0, OP_WR, 1'b1, 24'h000207, 32'h0000_ddd4, 4'h3, 32'h0);
		set_row(6, "rd16_l0", 0, OP_RD, 1'b1, 24'h000204, 32'h0, 4'h0, 32'h0000_aaa1);
		set_row(7, "rd16_l1", 0, OP_RD, 1'b1, 24'h000205, 32'h0, 4'h0, 32'h0000_bbb2);
		set_row(8, "rd16_l2", 0, OP_RD, 1'b1, 24'h000206, 32'h0, 4'h0, 32'h0000_ccc3);
		set_row(9, "rd16_l3", 0, OP_RD, 1'b1, 24'h000207, 32'h0, 4'h0, 32'h0000_ddd4);
		set_row(10, "rd32_hi", 0, OP_RD, 1'b0, 24'h000204, 32'h0, 4'h0, 32'haaa1_bbb2);
		set_row(11, "rd32_lo", 0, OP_RD, 1'b0, 24'h000206, 32'h0, 4'h0, 32'hccc3_ddd4);
		set_row(12, "miss_c1", 1, OP_RD, 1'b0, 24'h001008, 32'h0, 4'h0, 32'h0600_0402);
		set_row(13, "hit_c1", 1, OP_RD, 1'b0, 24'h00100e, 32'h0, 4'h0, 32'he600_0403);
		set_row(14, "upd_wr_c1", 1, OP_WR, 1'b0, 24'h001008, 32'hcafe_f00d, 4'hf, 32'h0);
		set_row(15, "upd_rd_c1", 1, OP_RD, 1'b0, 24'h001008, 32'h0, 4'h0, 32'hcafe_f00d);
		set_row(16, "pri_wr_c1", 1, OP_WR_POST, 1'b0, 24'h002000, 32'h5555_aaaa, 4'hf, 32'h0);
		set_row(17, "pri_wr_c0", 0, OP_WR, 1'b0, 24'h000300, 32'h0f1e_2d3c, 4'hf, 32'h0);
		set_row(18, "pri_rd_c0", 0, OP_RD, 1'b0, 24'h000300, 32'h0, 4'h0, 32'h0f1e_2d3c);
		set_row(19, "pri_rd_c1", 1, OP_RD, 1'b0, 24'h002000, 32'h0, 4'h0, 32'h5555_aaaa);
	endtask

	// rows first..last go out together, then wait until the bus took all of them
	task automatic run_writes(input int first, input int last);
		int accepted;
		int target;
		target   = last - first + 1;
		accepted = 0;
		// lower client wins the bus first
		for (int c = 0; c < `DDRAM_CHANNELS; c++) begin
			for (int j = first; j <= last; j++) begin
				if (row_client[j] == c)
					checks.expect_write(row_name[j], {`DDRAM_BASE, row_addr[j][23:2]});
			end
		end
		@(posedge clk);
		for (int j = first; j <= last; j++) begin
			mem_addr[row_client[j]] <= row_addr[j];
			mem_din[row_client[j]]  <= row_data[j];
			mem_16b[row_client[j]]  <= row_w16[j];
			mem_wr[row_client[j]]   <= row_mask[j];
		end
		@(posedge clk);
		for (int j = first; j <= last; j++)
			mem_wr[row_client[j]] <= '0;
		while (accepted < target) begin
			@(negedge clk);
			if (ddram_we && !ddram_busy)
				accepted++;
		end
	endtask

	task automatic run_read(input int idx);
		int   c;
		logic miss;
		c = row_client[idx];
		// one cached line per client, a read outside it needs a fill
		miss = (line_tag_t'(row_addr[idx] >> LINE_SHIFT) != open_line[c]);
		open_line[c] = line_tag_t'(row_addr[idx] >> LINE_SHIFT);
		@(posedge clk);
		checks.expect_read(row_name[idx], c, row_expect[idx], miss);
		mem_addr[c] <= row_addr[idx];
		mem_16b[c]  <= row_w16[idx];
		mem_rd[c]   <= 1'b1;
		@(posedge clk);
		mem_rd[c] <= 1'b0;
		do begin
			@(negedge clk);
		end while (mem_busy[c]);
	endtask

	task automatic report_results();
		int read_rows;
		int errors;
		read_rows = 0;
		for (int i = 0; i < N_ROWS; i++) begin
			if (row_op[i] == OP_RD)
				read_rows++;
		end
		if (checks.reads_done != read_rows) begin
			tb_errors++;
			$display("only %0d of %0d reads finished", checks.reads_done, read_rows);
		end
		if (checks.writes_outstanding() != 0) begin
			tb_errors++;
			$display("%0d queued writes never reached the DDR bus", checks.writes_outstanding());
		end
		errors = checks.error_count + tb_errors;
		$display("checks %0d, errors %0d, cycles %0d", checks.check_count, errors, cycle_count);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin : main
		int i;
		int first;
		for (int c = 0; c < `DDRAM_CHANNELS; c++) begin
			mem_addr[c]  = '0;
			mem_din[c]   = '0;
			mem_rd[c]    = 1'b0;
			mem_wr[c]    = '0;
			mem_16b[c]   = 1'b0;
			open_line[c] = '1;
		end
		load_table();
		repeat (5) @(posedge clk);
		rst_pulse <= 1'b0;
		i = 0;
		while (i < N_ROWS) begin
			if (row_op[i] == OP_RD) begin
				run_read(i);
				i++;
			end else begin
				first = i;
				while (row_op[i] == OP_WR_POST)
					i++;
				run_writes(first, i);
				i++;
			end
		end
		repeat (4) @(posedge clk);
		report_results();
	end

endmodule

// File: ddram.f
+incdir+.
ddr_bus_pkg.sv
mem_port_pkg.sv
ddr_write_fifo.sv
ddr_line_cache.sv
ddr_client_port.sv
ddr_arbiter.sv
ddram.sv
tb_ddram_checker.sv
tb_ddram.sv
